//--- sim.f
+incdir+.
isa_pkg.sv
axi_lite_pkg.sv
pc.sv
next_pc_decoder.sv
imem_axi_reader.sv
fetch_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_fetch -f sim.f -o tb_fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_fetch_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

//--- tb_fetch.sv
`include "fetch_defines.svh"

module tb_fetch
  import isa_pkg::*;
  import axi_lite_pkg::*;
();

  localparam int IMG_WORDS    = 256;
  localparam int RESET_CYCLES = 16;
  // segment starts as word indices
  localparam int T2_WORD   = 12;
  localparam int J_WORD    = 32;
  localparam int T3_WORD   = 56;
  localparam int T4_WORD   = 68;
  localparam int T5_WORD   = 100;
  localparam int HALT_WORD = 104;
  // bound on extra retirements from the capped backward loops
  localparam int LOOP_EXTRA = 24;

  logic        CLK;
  logic        rst_n;
  logic        reset_req;
  axi_ar_t     ar;
  axi_r_t      r;
  logic        arvalid;
  logic        arready;
  logic        rvalid;
  logic        rready;
  logic [31:0] jr_addr;
  logic        zero;
  logic        stall;
  instr_t      instr;
  logic        instr_valid;
  logic [31:0] imemaddr;
  logic        halt;
  int          errors;
  int          reads;

  logic [31:0] image [IMG_WORDS];
  int          visits [IMG_WORDS];
  logic [31:0] jr_target;
  logic        stall_en;
  int          budget_cycles = 0;
  int          err_mark = 0;

  tb_clock_gen clk_gen_i (.CLK(CLK), .rst_n(rst_n), .reset_req(reset_req));

  fetch_top dut_i (.*);

  tb_checker checker_i (.*);

  // random non-control word as either an addi or an r-type add
  function automatic logic [31:0] seq_word();
    logic [31:0] w;
    w = $urandom;
    if (w[0])
      seq_word = {6'h08, w[25:0]};
    else
      seq_word = {6'h00, w[25:11], 5'd0, 6'h20};
  endfunction

  function automatic logic [31:0] branch_word(input logic [5:0] op, input int off);
    logic [31:0] w;
    w = $urandom;
    branch_word = {op, w[9:0], off[15:0]};
  endfunction

  task automatic build_image();
    for (int i = 0; i < IMG_WORDS; i++)
    begin
      // the pattern for unreached words mixes the whole index
      image[i]  = {6'h08, 26'(i * 32'h0001_9e37 + 32'h0035_a5c3)};
      visits[i] = 0;
    end
    for (int i = 0; i < HALT_WORD; i++)
      image[i] = seq_word();
    // jr lands in the sled 16..31
    // j at word 32 lands in 40..55
    image[T2_WORD] = {6'h00, 5'($urandom), 15'd0, 6'h08};
    jr_target      = 32'(16 + $urandom % 16) << 2;
    image[J_WORD]  = {6'h02, 26'(40 + $urandom % 16)};
    // two forward branches then two backward ones onto word 63
    image[56] = branch_word(6'h04, 3);
    image[60] = branch_word(6'h05, 2);
    image[65] = branch_word(6'h04, -3);
    image[66] = branch_word(6'h05, -4);
    image[HALT_WORD] = {6'h3f, 26'd0};
  endtask

  // r payload plus the datapath inputs for the word being fetched
  task automatic load_beat(input logic [31:0] a);
    logic [31:0] w;
    int          idx;
    if (a >= 32'(IMG_WORDS * 4))
    begin
      r.data = 32'd0;
      r.resp = SLVERR;
    end
    else
    begin
      idx = int'(a >> 2);
      w   = image[idx];
      visits[idx]++;
      r.data  = w;
      r.resp  = OKAY;
      jr_addr = (w[31:26] == 6'h00 && w[5:0] == 6'h08) ? jr_target :
                32'($urandom % IMG_WORDS) << 2;
      zero = 1'($urandom);
      // backward branches fall through after two passes
      if ((w[31:26] == 6'h04 || w[31:26] == 6'h05) && w[15] && visits[idx] > 2)
        zero = (w[31:26] == 6'h05);
    end
  endtask

  // axi4-lite slave with 0 to 3 cycles of ready delay on both channels
  initial
  begin : mem_model
    logic        ar_fire;
    logic        r_fire;
    logic [31:0] a;
    int          ar_delay;
    int          r_delay;
    logic        pending;
    arready  = 1'b0;
    rvalid   = 1'b0;
    r        = '0;
    zero     = 1'b0;
    jr_addr  = '0;
    ar_delay = 0;
    r_delay  = 0;
    pending  = 1'b0;
    forever
    begin
      @(posedge CLK);
      ar_fire = arvalid && arready;
      r_fire  = rvalid && rready;
      a       = ar.addr;
      #10;
      if (!rst_n)
      begin
        arready = 1'b0;
        rvalid  = 1'b0;
        pending = 1'b0;
      end
      else
      begin
        if (r_fire)
          rvalid = 1'b0;
        if (ar_fire)
        begin
          arready  = 1'b0;
          ar_delay = int'($urandom % 4);
          r_delay  = int'($urandom % 4);
          pending  = 1'b1;
          load_beat(a);
        end
        if (pending && r_delay == 0)
        begin
          rvalid  = 1'b1;
          pending = 1'b0;
        end
        else if (pending)
          r_delay--;
        if (arvalid && !arready)
        begin
          if (ar_delay == 0)
            arready = 1'b1;
          else
            ar_delay--;
        end
      end
    end
  end

  // stall spans of 1 to 6 cycles while enabled
  initial
  begin : stall_drive
    int span;
    stall = 1'b0;
    span  = 0;
    forever
    begin
      @(posedge CLK);
      #10;
      if (span > 0)
        span--;
      else
      begin
        stall = stall_en ? 1'($urandom) : 1'b0;
        span  = 1 + int'($urandom % 6);
      end
    end
  end

  initial
  begin : watchdog
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge CLK);
    $display("timeout: the fetch run did not finish within %0d cycles", budget_cycles);
    $display("TEST FAILED");
    $finish;
  end

  task automatic wait_read_at(input int word);
    @(posedge CLK);
    while (!(arvalid && arready && ar.addr == (32'(word) << 2)))
      @(posedge CLK);
  endtask

  task automatic wait_halt();
    @(posedge CLK);
    while (!halt)
      @(posedge CLK);
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %s, %0d errors", name, (errors == err_mark) ? "ok" : "failed",
             errors - err_mark);
    err_mark = errors;
  endtask

  initial
  begin : run_tests
    void'($urandom(59));
    reset_req = 1'b0;
    stall_en  = 1'b0;
    build_image();
    // two resets plus a wide allowance per retired instruction
    budget_cycles = 2 * RESET_CYCLES + 200 * (HALT_WORD + 1 + LOOP_EXTRA + 2);
    wait_read_at(T2_WORD);
    finish_test("1 sequential reads from reset");
    wait_read_at(T3_WORD);
    finish_test("2 jr and j to random targets");
    wait_read_at(T4_WORD);
    finish_test("3 beq and bne with random zero");
    stall_en = 1'b1;
    wait_read_at(T5_WORD);
    stall_en = 1'b0;
    finish_test("4 random stall spans");
    wait_halt();
    // any read in this quiet window is flagged by the checker
    repeat (20) @(posedge CLK);
    // second run jumps to word 256 just past the image
    image[0] = {6'h02, 26'(IMG_WORDS)};
    #10 reset_req = 1'b1;
    @(posedge rst_n);
    reset_req = 1'b0;
    wait_halt();
    repeat (20) @(posedge CLK);
    finish_test("5 halt and slverr stop fetching");
    $display("5 tests done, %0d reads checked, %0d errors", reads, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- tb_checker.sv
`include "fetch_defines.svh"

module tb_checker
  import isa_pkg::*;
  import axi_lite_pkg::*;
(
  input  logic                     CLK,
  input  logic                     rst_n,
  input  axi_ar_t                  ar,
  input  logic                     arvalid,
  input  logic                     arready,
  input  axi_r_t                   r,
  input  logic                     rvalid,
  input  logic                     rready,
  input  instr_t                   instr,
  input  logic                     instr_valid,
  input  logic [`FETCH_ADDR_W-1:0] imemaddr,
  input  logic                     halt,
  input  logic [`FETCH_ADDR_W-1:0] jr_addr,
  input  logic                     zero,
  input  logic                     stall,
  output int                       errors,
  output int                       reads
);

  int          err_cnt = 0;
  int          read_cnt = 0;
  logic [31:0] model_pc;
  logic        model_halt;
  logic        beat_err;
  logic [31:0] beat_word;
  logic        beat_seen;
  logic        read_open;
  logic        prev_stall;
  logic        prev_arvalid;

  assign errors = err_cnt;
  assign reads  = read_cnt;

  // next fetch address from the current one and the retired word
  // mips field positions with opcode in 31:26 and funct in 5:0
  function automatic logic [31:0] expected_next_pc(input logic [31:0] cur,
                                                   input logic [31:0] w,
                                                   input logic        z,
                                                   input logic [31:0] jr);
    logic [31:0] seq;
    seq = cur + 32'd4;
    expected_next_pc = seq;
    if (w[31:26] == 6'h00 && w[5:0] == 6'h08)
      expected_next_pc = jr;
    else if (w[31:26] == 6'h02)
      expected_next_pc = {seq[31:28], w[25:0], 2'b00};
    else if ((w[31:26] == 6'h04 && z) || (w[31:26] == 6'h05 && !z))
      expected_next_pc = seq + {{14{w[15]}}, w[15:0], 2'b00};
    else if (w[31:26] == 6'h3f)
      expected_next_pc = cur;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: got %0h expected %0h at %0t", name, got, exp, $time);
    err_cnt++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    err_cnt++;
  endtask

  // all values read here are the ones from before the edge
  always @(posedge CLK)
  begin
    if (!rst_n)
    begin
      model_pc     = `FETCH_RESET_PC;
      model_halt   = 1'b0;
      beat_err     = 1'b0;
      beat_word    = '0;
      beat_seen    = 1'b0;
      read_open    = 1'b0;
      prev_stall   = 1'b0;
      prev_arvalid = 1'b0;
    end
    else
    begin
      if (imemaddr !== model_pc)
        report_mismatch("imemaddr", imemaddr, model_pc);
      if (halt !== model_halt)
        report_mismatch("halt", 32'(halt), 32'(model_halt));
      if (arvalid && model_halt)
        report_failure("a read address was issued after halt");
      // a stalled idle reader must not start a read
      if (arvalid && !prev_arvalid && prev_stall)
        report_failure("a new read address was issued while stall was high");
      // only one read may be in flight and rready belongs to it
      if (arvalid && read_open)
        report_failure("a second read address was issued with a read in flight");
      if (rready && !read_open)
        report_failure("rready was high with no read in flight");
      if (arvalid && arready)
      begin
        read_cnt++;
        read_open = 1'b1;
        if (beat_seen)
          report_failure("a new read was issued before the last beat retired");
        if (ar.addr !== model_pc)
          report_mismatch("ar.addr", ar.addr, model_pc);
        if (ar.prot !== 3'b100)
          report_mismatch("ar.prot", 32'(ar.prot), 32'h4);
      end
      if (rvalid && rready)
      begin
        beat_err  = (r.resp != OKAY);
        beat_word = r.data;
        beat_seen = 1'b1;
        read_open = 1'b0;
      end
      // retirement moves the model unless the beat was an error
      if (instr_valid)
      begin
        if (!beat_seen)
          report_failure("instr_valid pulsed without a read beat before it");
        else if (32'(instr) !== beat_word)
          report_mismatch("instr", 32'(instr), beat_word);
        if (!beat_err)
          model_pc = expected_next_pc(model_pc, beat_word, zero, jr_addr);
        if (beat_err || beat_word[31:26] == 6'h3f)
          model_halt = 1'b1;
        beat_seen = 1'b0;
      end
      prev_stall   = stall;
      prev_arvalid = arvalid;
    end
  end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
  output logic CLK,
  output logic rst_n,
  input  logic reset_req
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;

  // free running clock, period 100
  initial
  begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  // reset at time zero, and again on every request from the test sequence
  // release lands 10 units after an edge like the other driven inputs
  initial
  begin
    rst_n = 1'b0;
    forever
    begin
      repeat (RESET_CYCLES) @(posedge CLK);
      #10 rst_n = 1'b1;
      @(posedge reset_req);
      rst_n = 1'b0;
    end
  end

endmodule

//--- fetch_top.sv
`include "fetch_defines.svh"

module fetch_top
  import isa_pkg::*;
  import axi_lite_pkg::*;
(
  input  logic                     CLK,
  input  logic                     rst_n,
  // axi4-lite read channels toward instruction memory
  output axi_ar_t                  ar,
  output logic                     arvalid,
  input  logic                     arready,
  input  axi_r_t                   r,
  input  logic                     rvalid,
  output logic                     rready,
  // from the datapath
  input  logic [`FETCH_ADDR_W-1:0] jr_addr,
  input  logic                     zero,
  input  logic                     stall,
  // toward the rest of the cpu
  output instr_t                   instr,
  output logic                     instr_valid,
  output logic [`FETCH_ADDR_W-1:0] imemaddr,
  output logic                     halt
);

  logic      done;
  axi_resp_e resp;
  pc_src_e   pc_src;

  // done marks retirement and moves the pc on the same edge
  assign instr_valid = done;

  imem_axi_reader reader_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .addr    (imemaddr),
    .stall   (stall),
    .halt    (halt),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .r       (r),
    .rvalid  (rvalid),
    .rready  (rready),
    .done    (done),
    .rdata   (instr),
    .resp    (resp)
  );

  next_pc_decoder decoder_i (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .done   (done),
    .instr  (instr),
    .resp   (resp),
    .zero   (zero),
    .pc_src (pc_src),
    .halt   (halt)
  );

  // jump target is the low 26 bits of the word
  pc pc_i (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .advance  (done),
    .pc_src   (pc_src),
    .jr_addr  (jr_addr),
    .imm16    (instr.low.imm16),
    .addr26   (instr[25:0]),
    .imemaddr (imemaddr)
  );

endmodule

//--- imem_axi_reader.sv
`include "fetch_defines.svh"

module imem_axi_reader
  import isa_pkg::*;
  import axi_lite_pkg::*;
(
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic [`FETCH_ADDR_W-1:0] addr,
  input  logic                     stall,
  input  logic                     halt,
  output axi_ar_t                  ar,
  output logic                     arvalid,
  input  logic                     arready,
  input  axi_r_t                   r,
  input  logic                     rvalid,
  output logic                     rready,
  output logic                     done,
  output instr_t                   rdata,
  output axi_resp_e                resp
);

  // idle waits to issue, addr drives arvalid, data waits for the beat
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } state_e;

  state_e    state_q;
  state_e    state_d;
  logic      done_q;
  logic      beat;
  instr_t    rdata_q;
  axi_resp_e resp_q;

  // r channel transfer this cycle
  assign beat = (state_q == DATA) && rvalid;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        // wait out the retire cycle so pc and halt are current
        if (!done_q && !stall && !halt)
        begin
          state_d = ADDR;
        end
      end
      ADDR:
      begin
        if (arready)
        begin
          state_d = DATA;
        end
      end
      DATA:
      begin
        if (rvalid)
        begin
          state_d = IDLE;
        end
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // one cycle pulse after the beat lands
      done_q  <= beat;
    end
  end

  // beat payload
  always_ff @(posedge CLK)
  begin
    if (beat)
    begin
      rdata_q <= instr_t'(r.data);
      resp_q  <= r.resp;
    end
  end

  // pc only moves on done, so the address is steady while arvalid is up
  assign ar.addr = addr;
  assign ar.prot = PROT_INSTR;
  assign arvalid = (state_q == ADDR);
  assign rready  = (state_q == DATA);

  assign done  = done_q;
  assign rdata = rdata_q;
  assign resp  = resp_q;

endmodule

//--- next_pc_decoder.sv
module next_pc_decoder
  import isa_pkg::*;
  import axi_lite_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      done,
  input  instr_t    instr,
  input  axi_resp_e resp,
  input  logic      zero,
  output pc_src_e   pc_src,
  output logic      halt
);

  pc_src_e dec_src;
  logic    bad_beat;
  logic    is_halt_op;
  logic    halt_q;

  // a failed read carries no usable instruction
  assign bad_beat = (resp != OKAY);

  assign is_halt_op = (instr.opcode == HALT);

  // instruction to next-address source
  always_comb
  begin
    dec_src = SEL_NXT;
    case (instr.opcode)
      RTYPE:
      begin
        // only jr leaves the sequential path among r-types
        if (instr.low.r.funct == JR)
        begin
          dec_src = SEL_JR;
        end
      end
      J:
      begin
        dec_src = SEL_ADDR26;
      end
      BEQ:
      begin
        // zero high means the operands compared equal
        if (zero)
        begin
          dec_src = SEL_IMM16;
        end
      end
      BNE:
      begin
        if (!zero)
        begin
          dec_src = SEL_IMM16;
        end
      end
      HALT:
      begin
        dec_src = SEL_HOLD;
      end
      default:
      begin
        dec_src = SEL_NXT;
      end
    endcase
  end

  // once halted, or on an error beat, the fetch address is frozen
  assign pc_src = (halt_q || bad_beat) ? SEL_HOLD : dec_src;

  // sticky halt, cleared only by reset
  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      halt_q <= 1'b0;
    end
    else if (done && (is_halt_op || bad_beat))
    begin
      halt_q <= 1'b1;
    end
  end

  assign halt = halt_q;

endmodule

//--- pc.sv
`include "fetch_defines.svh"

module pc
  import isa_pkg::*;
(
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     advance,
  input  pc_src_e                  pc_src,
  input  logic [`FETCH_ADDR_W-1:0] jr_addr,
  input  logic [15:0]              imm16,
  input  logic [25:0]              addr26,
  output logic [`FETCH_ADDR_W-1:0] imemaddr
);

  logic [`FETCH_ADDR_W-1:0] pc_q;
  logic [`FETCH_ADDR_W-1:0] pc_d;
  logic [`FETCH_ADDR_W-1:0] seq_addr;
  logic [`FETCH_ADDR_W-1:0] br_offset;
  logic [`FETCH_ADDR_W-1:0] jmp_addr;

  // address of the instruction after this one
  assign seq_addr = pc_q + `FETCH_ADDR_W'(`FETCH_INSTR_BYTES);

  // word offset, sign extended to full width then turned into bytes
  assign br_offset = {{(`FETCH_ADDR_W - 16 - `FETCH_WORD_SHIFT){imm16[15]}},
                      imm16, {`FETCH_WORD_SHIFT{1'b0}}};

  // jump stays inside the current 256 MB region of the sequential address
  assign jmp_addr = {seq_addr[`FETCH_ADDR_W-1 -: `FETCH_JUMP_HI_W], addr26,
                     {`FETCH_WORD_SHIFT{1'b0}}};

  // next address mux
  always_comb
  begin
    case (pc_src)
      SEL_NXT:    pc_d = seq_addr;
      SEL_JR:     pc_d = jr_addr;
      SEL_ADDR26: pc_d = jmp_addr;
      SEL_IMM16:  pc_d = seq_addr + br_offset;
      // halt and any unused code keep the address
      default:    pc_d = pc_q;
    endcase
  end

  // fetch address register, only moves when an instruction retires
  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      pc_q <= `FETCH_RESET_PC;
    end
    else if (advance)
    begin
      pc_q <= pc_d;
    end
  end

  assign imemaddr = pc_q;

endmodule

//--- axi_lite_pkg.sv
`include "fetch_defines.svh"

package axi_lite_pkg;

  // read response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // arprot for an unprivileged, secure instruction access
  // bit 2 marks the access as instruction fetch
  localparam logic [2:0] PROT_INSTR = 3'b100;

  // read address channel payload
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] addr;
    logic [2:0]               prot;
  } axi_ar_t;

  // read data channel payload
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] data;
    axi_resp_e                resp;
  } axi_r_t;

endpackage

//--- isa_pkg.sv
`include "fetch_defines.svh"

package isa_pkg;

  // primary opcodes the fetch side cares about
  // any other code is treated as a sequential instruction
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    HALT  = 6'h3f
  } opcode_e;

  // r-type function codes, only jr changes control flow
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    JR   = 6'h08,
    ADD  = 6'h20,
    ADDU = 6'h21,
    SUB  = 6'h22,
    SUBU = 6'h23,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } funct_e;

  // where the next fetch address comes from
  typedef enum logic [2:0] {
    SEL_NXT,
    SEL_JR,
    SEL_ADDR26,
    SEL_IMM16,
    SEL_HOLD
  } pc_src_e;

  // low half of an r-type word
  typedef struct packed {
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_e     funct;
  } rtail_t;

  // the low 16 bits read either as an immediate or as the r-type tail
  typedef union packed {
    logic [15:0] imm16;
    rtail_t      r;
  } low16_u;

  // full instruction word, jump target is the low 26 bits of it
  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    low16_u     low;
  } instr_t;

endpackage

//--- fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// fixed widths and reset values for the fetch side
// everything here follows from the instruction set

// address width, also the instruction word width
`define FETCH_ADDR_W 32

// byte step between consecutive instructions
// pc arithmetic uses this for the sequential address
`define FETCH_INSTR_BYTES 4

// first fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

// jump targets keep this many upper bits of the sequential address
`define FETCH_JUMP_HI_W 4

// branch offsets are word offsets, shifted left by this much
`define FETCH_WORD_SHIFT 2

`endif
